// ==== logic/bus_cycle_if.sv ====
`timescale 1ns/1ps

interface bus_cycle_if;

    import xt_bus_pkg::*;

    cycle_kind_t kind;
    bus_target_t target;
    logic        cycle_start;
    logic        active;

    modport decoder
    (
        output kind,
        output target,
        output cycle_start,
        output active
    );

    modport consumer
    (
        input kind,
        input target,
        input cycle_start,
        input active
    );

endinterface

// ==== logic/xt_bus_core.sv ====
`timescale 1ns/1ps

module xt_bus_core
(
    input  logic                        clock,
    input  logic                        reset,
    // Command strobes and latched address
    input  logic                        memory_read_n,
    input  logic                        memory_write_n,
    input  logic                        io_read_n,
    input  logic                        io_write_n,
    input  xt_bus_pkg::addr_t           address,
    // Read data sources
    input  xt_bus_pkg::data_t           chipset_data,
    input  xt_bus_pkg::data_t           ram_data,
    input  xt_bus_pkg::data_t           external_data,
    // RAM wait mode
    input  xt_timing_pkg::wait_count_t  read_wait_cycles,
    input  xt_timing_pkg::wait_count_t  write_wait_cycles,
    input  logic                        io_channel_ready,
    // Refresh
    input  logic                        timer_1_out,
    input  logic                        dma_acknowledge_0_n,
    output logic                        processor_ready,
    output logic                        dma_request_0,
    output xt_bus_pkg::data_t           data_bus,
    output logic                        data_bus_direction
);

    bus_cycle_if cycle_bus ();

    xt_cycle_decode xt_cycle_decode_inst
    (
        .clock                  (clock),
        .reset                  (reset),
        .memory_read_n          (memory_read_n),
        .memory_write_n         (memory_write_n),
        .io_read_n              (io_read_n),
        .io_write_n             (io_write_n),
        .address                (address),
        .cycle                  (cycle_bus.decoder)
    );

    xt_wait_refresh xt_wait_refresh_inst
    (
        .clock                  (clock),
        .reset                  (reset),
        .cycle                  (cycle_bus.consumer),
        .read_wait_cycles       (read_wait_cycles),
        .write_wait_cycles      (write_wait_cycles),
        .io_channel_ready       (io_channel_ready),
        .timer_1_out            (timer_1_out),
        .dma_acknowledge_0_n    (dma_acknowledge_0_n),
        .processor_ready        (processor_ready),
        .dma_request_0          (dma_request_0)
    );

    // Data path is purely combinational from strobes to bus
    xt_read_steer xt_read_steer_inst
    (
        .cycle                  (cycle_bus.consumer),
        .chipset_data           (chipset_data),
        .ram_data               (ram_data),
        .external_data          (external_data),
        .data_bus               (data_bus),
        .data_bus_direction     (data_bus_direction)
    );

endmodule

// ==== logic/xt_bus_defs.svh ====
`ifndef XT_BUS_DEFS_SVH
`define XT_BUS_DEFS_SVH

// Bus widths
`define XT_ADDR_WIDTH 20
`define XT_DATA_WIDTH 8

// First memory address above conventional RAM
`define XT_RAM_TOP 20'hA0000

// I/O ports below this belong to the chipset
`define XT_CHIPSET_IO_TOP 16'h0100

// RAM wait count width, 0 to 3 wait states
`define XT_WAIT_WIDTH 2

`endif

// ==== logic/xt_bus_pkg.sv ====
`include "xt_bus_defs.svh"

package xt_bus_pkg;

    typedef logic [`XT_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`XT_DATA_WIDTH-1:0] data_t;

    // One kind per active strobe
    typedef enum logic [2:0]
    {
        cycle_idle,
        cycle_mem_read,
        cycle_mem_write,
        cycle_io_read,
        cycle_io_write
    } cycle_kind_t;

    typedef enum logic [1:0]
    {
        target_chipset,
        target_ram,
        target_external
    } bus_target_t;

endpackage

// ==== logic/xt_cycle_decode.sv ====
`timescale 1ns/1ps
`include "xt_bus_defs.svh"

module xt_cycle_decode
(
    input  logic                clock,
    input  logic                reset,
    input  logic                memory_read_n,
    input  logic                memory_write_n,
    input  logic                io_read_n,
    input  logic                io_write_n,
    input  xt_bus_pkg::addr_t   address,
    bus_cycle_if.decoder        cycle
);

    import xt_bus_pkg::*;

    cycle_kind_t kind;
    cycle_kind_t previous_kind;

    // Exactly one strobe low, anything else is idle
    always_comb
    begin
        case ({memory_read_n, memory_write_n, io_read_n, io_write_n})
            4'b0111: kind = cycle_mem_read;
            4'b1011: kind = cycle_mem_write;
            4'b1101: kind = cycle_io_read;
            4'b1110: kind = cycle_io_write;
            default: kind = cycle_idle;
        endcase
    end

    always_comb
    begin
        if ((kind == cycle_mem_read) || (kind == cycle_mem_write))
            cycle.target = (address < `XT_RAM_TOP) ? target_ram : target_external;
        else if ((kind == cycle_io_read) || (kind == cycle_io_write))
            cycle.target = (address[15:0] < `XT_CHIPSET_IO_TOP) ? target_chipset
                                                                 : target_external;
        else
            cycle.target = target_external;
    end

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            previous_kind <= cycle_idle;
        else
            previous_kind <= kind;
    end

    assign cycle.kind        = kind;
    assign cycle.active      = (kind != cycle_idle);
    // High until the first edge that sees the new kind
    assign cycle.cycle_start = (kind != cycle_idle) && (kind != previous_kind);

endmodule

// ==== logic/xt_read_steer.sv ====
`timescale 1ns/1ps

module xt_read_steer
(
    bus_cycle_if.consumer       cycle,
    input  xt_bus_pkg::data_t   chipset_data,
    input  xt_bus_pkg::data_t   ram_data,
    input  xt_bus_pkg::data_t   external_data,
    output xt_bus_pkg::data_t   data_bus,
    output logic                data_bus_direction
);

    import xt_bus_pkg::*;

    logic is_read;

    assign is_read = (cycle.kind == cycle_io_read) || (cycle.kind == cycle_mem_read);

    // Chipset first, then RAM, then the external bus
    always_comb
    begin
        if ((cycle.kind == cycle_io_read) && (cycle.target == target_chipset))
        begin
            data_bus           = chipset_data;
            data_bus_direction = 1'b0;
        end
        else if ((cycle.kind == cycle_mem_read) && (cycle.target == target_ram))
        begin
            data_bus           = ram_data;
            data_bus_direction = 1'b0;
        end
        else if (is_read && (cycle.target == target_external))
        begin
            data_bus           = external_data;
            data_bus_direction = 1'b1;
        end
        else
        begin
            data_bus           = '0;
            data_bus_direction = 1'b0;
        end
    end

endmodule

// ==== logic/xt_timing_pkg.sv ====
`include "xt_bus_defs.svh"

package xt_timing_pkg;

    // Number of RAM wait states
    typedef logic [`XT_WAIT_WIDTH-1:0] wait_count_t;

    // RAM wait-state FSM
    typedef enum logic [1:0]
    {
        wait_idle,
        wait_count,
        wait_hold
    } wait_state_t;

endpackage

// ==== logic/xt_wait_refresh.sv ====
`timescale 1ns/1ps

module xt_wait_refresh
(
    input  logic                        clock,
    input  logic                        reset,
    bus_cycle_if.consumer               cycle,
    input  xt_timing_pkg::wait_count_t  read_wait_cycles,
    input  xt_timing_pkg::wait_count_t  write_wait_cycles,
    input  logic                        io_channel_ready,
    input  logic                        timer_1_out,
    input  logic                        dma_acknowledge_0_n,
    output logic                        processor_ready,
    output logic                        dma_request_0
);

    import xt_bus_pkg::*;
    import xt_timing_pkg::*;

    wait_state_t state;
    wait_count_t wait_counter;
    wait_count_t load_count;
    logic        ram_cycle_start;
    logic        previous_timer_1;

    assign ram_cycle_start = cycle.cycle_start && (cycle.target == target_ram)
                             && ((cycle.kind == cycle_mem_read)
                                 || (cycle.kind == cycle_mem_write));

    assign load_count = (cycle.kind == cycle_mem_read) ? read_wait_cycles
                                                       : write_wait_cycles;

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            state        <= wait_idle;
            wait_counter <= '0;
        end
        else
        begin
            case (state)
                wait_idle:
                    if (ram_cycle_start)
                    begin
                        wait_counter <= load_count;
                        state        <= (load_count == '0) ? wait_hold : wait_count;
                    end
                wait_count:
                    // Keeps counting even while the channel holds the bus
                    if (!cycle.active)
                        state <= wait_idle;
                    else if (wait_counter == wait_count_t'(1))
                        state <= wait_hold;
                    else
                        wait_counter <= wait_counter - wait_count_t'(1);
                wait_hold:
                    if (!cycle.active)
                        state <= wait_idle;
                default:
                    state <= wait_idle;
            endcase
        end
    end

    assign processor_ready = io_channel_ready && (state != wait_count);

    // Refresh request on a rising edge of timer channel 1
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            previous_timer_1 <= 1'b1;
            dma_request_0    <= 1'b0;
        end
        else
        begin
            previous_timer_1 <= timer_1_out;
            if (!dma_acknowledge_0_n)
                dma_request_0 <= 1'b0;
            else if (!previous_timer_1 && timer_1_out)
                dma_request_0 <= 1'b1;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the xt_bus_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f xt_bus_core.f \
    --top-module xt_bus_core_tb \
    -o xt_bus_core_sim

./obj_dir/xt_bus_core_sim +verilator+error+limit+100 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi

// ==== verification/xt_bus_core_checker.sv ====
`timescale 1ns/1ps

module xt_bus_core_checker
(
    input logic clock,
    input logic reset,
    input logic memory_read_n,
    input logic io_read_n,
    input logic io_channel_ready,
    input logic processor_ready,
    input logic dma_acknowledge_0_n,
    input logic dma_request_0,
    input logic data_bus_direction
);

    int failure_count = 0;

    // Bus turns outward only during a read
    direction_on_read: assert property (@(posedge clock) disable iff (reset)
        !(data_bus_direction && io_read_n && memory_read_n))
    else
    begin
        failure_count++;
        $error("data_bus_direction high without a read strobe");
    end

    request_cleared_by_ack: assert property (@(posedge clock) disable iff (reset)
        $fell(dma_request_0) |-> !$past(dma_acknowledge_0_n))
    else
    begin
        failure_count++;
        $error("dma_request_0 fell without an acknowledge");
    end

    // Channel ready low always holds the processor
    ready_follows_channel: assert property (@(posedge clock) disable iff (reset)
        !(processor_ready && !io_channel_ready))
    else
    begin
        failure_count++;
        $error("processor_ready high while io_channel_ready low");
    end

endmodule

bind xt_bus_core xt_bus_core_checker xt_bus_core_checker_inst
(
    .clock                  (clock),
    .reset                  (reset),
    .memory_read_n          (memory_read_n),
    .io_read_n              (io_read_n),
    .io_channel_ready       (io_channel_ready),
    .processor_ready        (processor_ready),
    .dma_acknowledge_0_n    (dma_acknowledge_0_n),
    .dma_request_0          (dma_request_0),
    .data_bus_direction     (data_bus_direction)
);

// ==== verification/xt_bus_core_tb.sv ====
`timescale 1ns/1ps

module xt_bus_core_tb;

    import xt_bus_pkg::*;
    import xt_timing_pkg::*;

    localparam int timeout_cycles = 16;
    localparam int entry_count    = 14;

    // Order is memory read, memory write, I/O read, I/O write
    localparam logic [3:0] strobe_idle      = 4'b1111;
    localparam logic [3:0] strobe_mem_read  = 4'b0111;
    localparam logic [3:0] strobe_mem_write = 4'b1011;
    localparam logic [3:0] strobe_io_read   = 4'b1101;
    localparam logic [3:0] strobe_io_write  = 4'b1110;

    localparam int source_none     = 0;
    localparam int source_chipset  = 1;
    localparam int source_ram      = 2;
    localparam int source_external = 3;

    typedef struct packed
    {
        logic [3:0]  strobes;
        addr_t       address;
        wait_count_t read_wait;
        wait_count_t write_wait;
        int          stall_cycles;
        int          source;
        int          wait_states;
    } bus_entry_t;

    logic        clock;
    logic        reset;
    logic        memory_read_n;
    logic        memory_write_n;
    logic        io_read_n;
    logic        io_write_n;
    addr_t       address;
    data_t       chipset_data;
    data_t       ram_data;
    data_t       external_data;
    wait_count_t read_wait_cycles;
    wait_count_t write_wait_cycles;
    logic        io_channel_ready;
    logic        timer_1_out;
    logic        dma_acknowledge_0_n;
    logic        processor_ready;
    logic        dma_request_0;
    data_t       data_bus;
    logic        data_bus_direction;
    bus_entry_t  cycle_table [entry_count];

    xt_bus_core xt_bus_core_inst
    (
        .clock                  (clock),
        .reset                  (reset),
        .memory_read_n          (memory_read_n),
        .memory_write_n         (memory_write_n),
        .io_read_n              (io_read_n),
        .io_write_n             (io_write_n),
        .address                (address),
        .chipset_data           (chipset_data),
        .ram_data               (ram_data),
        .external_data          (external_data),
        .read_wait_cycles       (read_wait_cycles),
        .write_wait_cycles      (write_wait_cycles),
        .io_channel_ready       (io_channel_ready),
        .timer_1_out            (timer_1_out),
        .dma_acknowledge_0_n    (dma_acknowledge_0_n),
        .processor_ready        (processor_ready),
        .dma_request_0          (dma_request_0),
        .data_bus               (data_bus),
        .data_bus_direction     (data_bus_direction)
    );

    initial
    begin
        clock = 1'b0;
        forever
            #20 clock = ~clock;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            stop_with_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                        name, actual, expected));
    endtask

    task automatic check_assertions();
        if (xt_bus_core_inst.xt_bus_core_checker_inst.failure_count != 0)
            stop_with_failure("The bound checker reported an assertion failure");
    endtask

    // strobes, address, read wait, write wait, stall cycles, source, wait states
    task automatic build_table();
        cycle_table[0]  = '{strobe_io_read,   20'h00060, 2'd0, 2'd0, 0, source_chipset,  0};
        cycle_table[1]  = '{strobe_io_read,   20'h003F8, 2'd0, 2'd0, 0, source_external, 0};
        cycle_table[2]  = '{strobe_mem_read,  20'h01234, 2'd0, 2'd3, 0, source_ram,      0};
        cycle_table[3]  = '{strobe_mem_read,  20'h45678, 2'd1, 2'd0, 0, source_ram,      1};
        cycle_table[4]  = '{strobe_mem_read,  20'h9FFFF, 2'd2, 2'd0, 0, source_ram,      2};
        cycle_table[5]  = '{strobe_mem_read,  20'h00000, 2'd3, 2'd1, 0, source_ram,      3};
        cycle_table[6]  = '{strobe_mem_read,  20'hA0000, 2'd3, 2'd3, 0, source_external, 0};
        cycle_table[7]  = '{strobe_mem_read,  20'hF0000, 2'd2, 2'd2, 0, source_external, 0};
        cycle_table[8]  = '{strobe_mem_write, 20'h02000, 2'd3, 2'd2, 0, source_none,     2};
        cycle_table[9]  = '{strobe_mem_write, 20'h9FFF0, 2'd0, 2'd1, 0, source_none,     1};
        cycle_table[10] = '{strobe_io_read,   20'h00040, 2'd0, 2'd0, 4, source_chipset,  0};
        cycle_table[11] = '{strobe_mem_read,  20'h05000, 2'd1, 2'd0, 5, source_ram,      1};
        cycle_table[12] = '{strobe_io_write,  20'h00020, 2'd0, 2'd0, 0, source_none,     0};
        cycle_table[13] = '{strobe_mem_read,  20'h10000, 2'd3, 2'd0, 2, source_ram,      3};
    endtask

    task automatic step_refresh_inputs(input logic timer, input logic ack_n,
                                       input logic expected_request);
        @(posedge clock);
        timer_1_out         <= timer;
        dma_acknowledge_0_n <= ack_n;
        @(negedge clock);
        check_equal("dma_request_0", 32'(dma_request_0), 32'(expected_request));
    endtask

    task automatic run_bus_cycle(input bus_entry_t entry);
        data_t chipset_value;
        data_t ram_value;
        data_t external_value;
        data_t expected;
        int    edges;
        int    low_count;
        int    expected_low;
        logic  done;
        chipset_value  = data_t'($urandom);
        ram_value      = data_t'($urandom);
        external_value = data_t'($urandom);
        case (entry.source)
            source_chipset:  expected = chipset_value;
            source_ram:      expected = ram_value;
            source_external: expected = external_value;
            default:         expected = '0;
        endcase
        // Counter keeps running under back-pressure, so the longer one wins
        expected_low = (entry.stall_cycles - 1 > entry.wait_states) ? entry.stall_cycles - 1
                                                                    : entry.wait_states;
        @(posedge clock);
        {memory_read_n, memory_write_n, io_read_n, io_write_n} <= entry.strobes;
        address           <= entry.address;
        read_wait_cycles  <= entry.read_wait;
        write_wait_cycles <= entry.write_wait;
        chipset_data      <= chipset_value;
        ram_data          <= ram_value;
        external_data     <= external_value;
        io_channel_ready  <= (entry.stall_cycles == 0);
        @(negedge clock);
        check_equal("data_bus", 32'(data_bus), 32'(expected));
        check_equal("data_bus_direction", 32'(data_bus_direction),
                    32'(entry.source == source_external));
        check_equal("processor_ready", 32'(processor_ready), 32'(entry.stall_cycles == 0));
        edges     = 0;
        low_count = 0;
        done      = 1'b0;
        while (!done)
        begin
            @(posedge clock);
            edges++;
            if (edges == entry.stall_cycles)
                io_channel_ready <= 1'b1;
            @(negedge clock);
            if (processor_ready)
                done = 1'b1;
            else
                low_count++;
            if (low_count > timeout_cycles)
                stop_with_failure("processor_ready stayed low past the timeout");
        end
        check_equal("processor_ready low cycles", low_count, expected_low);
        check_equal("data_bus", 32'(data_bus), 32'(expected));
        @(posedge clock);
        {memory_read_n, memory_write_n, io_read_n, io_write_n} <= strobe_idle;
        io_channel_ready <= 1'b1;
        @(negedge clock);
        check_equal("data_bus", 32'(data_bus), 32'd0);
        check_equal("data_bus_direction", 32'(data_bus_direction), 32'd0);
    endtask

    initial
    begin
        void'($urandom(32'ha9a3_99d7));
        reset               = 1'b1;
        {memory_read_n, memory_write_n, io_read_n, io_write_n} = strobe_idle;
        address             = '0;
        chipset_data        = '0;
        ram_data            = '0;
        external_data       = '0;
        read_wait_cycles    = '0;
        write_wait_cycles   = '0;
        io_channel_ready    = 1'b1;
        timer_1_out         = 1'b1;
        dma_acknowledge_0_n = 1'b1;
        build_table();
        repeat (3)
            @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_equal("dma_request_0", 32'(dma_request_0), 32'd0);
        check_equal("processor_ready", 32'(processor_ready), 32'd1);

        // Timer rising edge, request held, then one acknowledge pulse
        step_refresh_inputs(1'b0, 1'b1, 1'b0);
        step_refresh_inputs(1'b1, 1'b1, 1'b0);
        step_refresh_inputs(1'b1, 1'b1, 1'b1);
        repeat (3)
            step_refresh_inputs(1'b1, 1'b1, 1'b1);
        step_refresh_inputs(1'b1, 1'b0, 1'b1);
        step_refresh_inputs(1'b1, 1'b1, 1'b0);
        repeat (3)
            step_refresh_inputs(1'b1, 1'b1, 1'b0);

        for (int i = 0; i < entry_count; i++)
        begin
            run_bus_cycle(cycle_table[i]);
            check_assertions();
        end

        if (xt_bus_core_inst.xt_bus_core_checker_inst.failure_count != 0)
            stop_with_failure("The bound checker reported an assertion failure");
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== xt_bus_core.f ====
+incdir+logic
logic/xt_bus_pkg.sv
logic/xt_timing_pkg.sv
logic/bus_cycle_if.sv
logic/xt_cycle_decode.sv
logic/xt_wait_refresh.sv
logic/xt_read_steer.sv
logic/xt_bus_core.sv
verification/xt_bus_core_checker.sv
verification/xt_bus_core_tb.sv
